/* kvs_net_defines.svh */
//----------------------------
// widths, FIFO depths, listen port range
// and start-up delay of the network wrapper
//----------------------------
`ifndef KVS_NET_DEFINES_SVH
`define KVS_NET_DEFINES_SVH

// packet and metadata widths
`define DATA_W 64
`define META_W 64
`define SESSION_W 16
`define LEN_W 16
`define TX_META_W 32

// length step per transmitted beat
`define BYTES_PER_BEAT 8

// FIFO address bits, depth is 2**AW
`define RX_FIFO_AW 8
`define TX_FIFO_AW 11
`define META_FIFO_AW 4

// server ports 2880..2887, end is exclusive
`define LISTEN_FIRST_PORT 16'h0B40
`define LISTEN_PORT_END 16'h0B48

// cycles after reset before the first listen request
`define LISTEN_DELAY 100

`endif

/* kvs_net_pkg.sv */
//----------------------------
// shared types of the network wrapper
//----------------------------
`default_nettype none

`include "kvs_net_defines.svh"

package kvs_net_pkg;

  // payload types
  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [`META_W-1:0] meta_t;

  // transmit metadata fields
  typedef logic [`SESSION_W-1:0] session_t;
  typedef logic [`LEN_W-1:0] len_t;

  // TCP port number
  typedef logic [15:0] port_t;

  // listen request sequencer
  typedef enum logic [1:0] {
    WAIT_START,
    OPENING,
    DONE
  } opener_state_t;

  // message framing on the transmit side
  typedef enum logic {
    FIRST_BEAT,
    BODY
  } framer_state_t;

endpackage

`default_nettype wire

/* stream_if.sv */
//----------------------------
// valid/ready word stream with last flag
//----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "kvs_net_defines.svh"

interface stream_if;

  logic                valid;
  logic                ready;
  kvs_net_pkg::word_t  data;
  logic                last;

  // producer side
  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  // consumer side
  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

/* stream_fifo.sv */
//----------------------------
// synchronous stream FIFO, 2**AW beats,
// registered output stage
//----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "kvs_net_defines.svh"

module stream_fifo #(
  parameter int AW = 4
) (
  input  logic    aclk,
  input  logic    aresetn,
  stream_if.sink   s_in,
  stream_if.source m_out
);

  localparam int DEPTH = 2 ** AW;

  // {last, data} per entry
  logic [`DATA_W:0] mem [DEPTH];
  logic [`DATA_W:0] out_beat;
  logic             out_valid;

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   mem_cnt;
  logic [AW:0]   used;

  logic push;
  logic out_free;
  logic rd_en;
  logic wr_en;

  // beats held in total, memory plus output stage
  assign used = mem_cnt + {{AW{1'b0}}, out_valid};
  // used never exceeds DEPTH, so its top bit marks full
  assign s_in.ready = ~used[AW];

  assign push     = s_in.valid & s_in.ready;
  assign out_free = ~out_valid | m_out.ready;
  assign rd_en    = out_free & (mem_cnt != '0);
  // an empty FIFO loads the output stage directly
  assign wr_en    = push & ~(out_free & (mem_cnt == '0));

  assign m_out.valid = out_valid;
  assign m_out.data  = out_beat[`DATA_W-1:0];
  assign m_out.last  = out_beat[`DATA_W];

  //----------------------------
  // storage
  //----------------------------
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {s_in.last, s_in.data};
    end
    if (rd_en) begin
      out_beat <= mem[rd_ptr];
    end else if (out_free && push) begin
      out_beat <= {s_in.last, s_in.data};
    end
  end

  //----------------------------
  // pointers and occupancy
  //----------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      mem_cnt   <= '0;
      out_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   mem_cnt <= mem_cnt + 1'b1;
        2'b01:   mem_cnt <= mem_cnt - 1'b1;
        default: mem_cnt <= mem_cnt;
      endcase
      if (out_free) begin
        out_valid <= rd_en | push;
      end
    end
  end

endmodule

`default_nettype wire

/* listen_port_opener.sv */
//----------------------------
// start-up timer and listen requests
// for the server port range
//----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "kvs_net_defines.svh"

module listen_port_opener (
  input  logic               aclk,
  input  logic               aresetn,
  output logic               listen_port_valid,
  input  logic               listen_port_ready,
  output kvs_net_pkg::port_t listen_port_data
);

  localparam int DELAY_W = $clog2(`LISTEN_DELAY + 1);

  kvs_net_pkg::opener_state_t state;
  logic [DELAY_W-1:0]         delay_cnt;
  kvs_net_pkg::port_t         next_port;
  logic                       strobe;

  // one-cycle request, never two in a row
  assign strobe = (state == kvs_net_pkg::OPENING) & ~listen_port_valid & listen_port_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state             <= kvs_net_pkg::WAIT_START;
      delay_cnt         <= '0;
      next_port         <= `LISTEN_FIRST_PORT;
      listen_port_valid <= 1'b0;
    end else begin
      listen_port_valid <= 1'b0;
      case (state)
        kvs_net_pkg::WAIT_START: begin
          delay_cnt <= delay_cnt + 1'b1;
          if (delay_cnt == DELAY_W'(`LISTEN_DELAY)) begin
            state <= kvs_net_pkg::OPENING;
          end
        end
        kvs_net_pkg::OPENING: begin
          if (strobe) begin
            listen_port_valid <= 1'b1;
            next_port         <= next_port + 16'd1;
            // last port of the range goes out now
            if (next_port == `LISTEN_PORT_END - 16'd1) begin
              state <= kvs_net_pkg::DONE;
            end
          end
        end
        kvs_net_pkg::DONE: begin
          // all ports requested
        end
        default: begin
          state <= kvs_net_pkg::WAIT_START;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (strobe) begin
      listen_port_data <= next_port;
    end
  end

endmodule

`default_nettype wire

/* tx_framer.sv */
//----------------------------
// transmit framing: beat pass-through,
// session capture, length count, meta queue
//----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "kvs_net_defines.svh"

module tx_framer (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   app_tx_valid,
  output logic                   app_tx_ready,
  input  kvs_net_pkg::word_t     app_tx_data,
  input  kvs_net_pkg::meta_t     app_tx_meta,
  input  logic                   app_tx_last,
  stream_if.source               beats_out,
  output logic                   tx_meta_valid,
  input  logic                   tx_meta_ready,
  output logic [`TX_META_W-1:0]  tx_meta_data
);

  localparam int QAW = `META_FIFO_AW;
  localparam int QDEPTH = 2 ** QAW;

  kvs_net_pkg::framer_state_t state;
  kvs_net_pkg::session_t      session;
  kvs_net_pkg::session_t      session_next;
  kvs_net_pkg::len_t          len;
  kvs_net_pkg::len_t          len_next;

  // registered push into the queue
  logic                  pend_valid;
  logic [`TX_META_W-1:0] pend_data;

  logic [`TX_META_W-1:0] qmem [QDEPTH];
  logic [QAW-1:0]        q_wr;
  logic [QAW-1:0]        q_rd;
  logic [QAW:0]          q_cnt;
  logic [QAW:0]          q_used;
  logic                  meta_full;
  logic                  q_pop;
  logic                  beat_xfer;
  logic                  hold_last;

  // room must be left for the pending entry
  assign q_used    = q_cnt + {{QAW{1'b0}}, pend_valid};
  assign meta_full = q_used[QAW];
  assign hold_last = app_tx_last & meta_full;

  assign app_tx_ready    = beats_out.ready & ~hold_last;
  assign beats_out.valid = app_tx_valid & ~hold_last;
  assign beats_out.data  = app_tx_data;
  assign beats_out.last  = app_tx_last;
  assign beat_xfer       = app_tx_valid & app_tx_ready;

  assign tx_meta_valid = (q_cnt != '0);
  assign tx_meta_data  = qmem[q_rd];
  assign q_pop         = tx_meta_valid & tx_meta_ready;

  always_comb begin
    if (state == kvs_net_pkg::FIRST_BEAT) begin
      session_next = app_tx_meta[`SESSION_W-1:0];
      len_next     = kvs_net_pkg::len_t'(`BYTES_PER_BEAT);
    end else begin
      session_next = session;
      len_next     = len + kvs_net_pkg::len_t'(`BYTES_PER_BEAT);
    end
  end

  //----------------------------
  // message state
  //----------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= kvs_net_pkg::FIRST_BEAT;
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= beat_xfer & app_tx_last;
      if (beat_xfer) begin
        state <= app_tx_last ? kvs_net_pkg::FIRST_BEAT : kvs_net_pkg::BODY;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (beat_xfer) begin
      session   <= session_next;
      len       <= len_next;
      // length in the high half
      pend_data <= {len_next, session_next};
    end
  end

  //----------------------------
  // metadata queue
  //----------------------------
  always_ff @(posedge aclk) begin
    if (pend_valid) begin
      qmem[q_wr] <= pend_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      q_wr  <= '0;
      q_rd  <= '0;
      q_cnt <= '0;
    end else begin
      if (pend_valid) begin
        q_wr <= q_wr + 1'b1;
      end
      if (q_pop) begin
        q_rd <= q_rd + 1'b1;
      end
      case ({pend_valid, q_pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

/* kvs_net_top.sv */
//----------------------------
// network side of the key-value store:
// listen requests, rx buffering, tx framing
//----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "kvs_net_defines.svh"

module kvs_net_top (
  input  logic                  aclk,
  input  logic                  aresetn,

  // listen requests to the TCP stack
  output logic                  listen_port_valid,
  input  logic                  listen_port_ready,
  output kvs_net_pkg::port_t    listen_port_data,

  // received packet words
  input  logic                  rx_data_valid,
  output logic                  rx_data_ready,
  input  kvs_net_pkg::word_t    rx_data_data,
  input  logic                  rx_data_last,

  // toward the application
  output logic                  app_rx_valid,
  input  logic                  app_rx_ready,
  output kvs_net_pkg::word_t    app_rx_data,
  output logic                  app_rx_last,

  // responses from the application
  input  logic                  app_tx_valid,
  output logic                  app_tx_ready,
  input  kvs_net_pkg::word_t    app_tx_data,
  input  kvs_net_pkg::meta_t    app_tx_meta,
  input  logic                  app_tx_last,

  // to the TCP stack
  output logic                  tx_data_valid,
  input  logic                  tx_data_ready,
  output kvs_net_pkg::word_t    tx_data_data,
  output logic                  tx_data_last,

  output logic                  tx_meta_valid,
  input  logic                  tx_meta_ready,
  output logic [`TX_META_W-1:0] tx_meta_data
);

  stream_if rx_in ();
  stream_if rx_app ();
  stream_if tx_beats ();
  stream_if tx_net ();

  //----------------------------
  // receive path
  //----------------------------
  assign rx_in.valid   = rx_data_valid;
  assign rx_in.data    = rx_data_data;
  assign rx_in.last    = rx_data_last;
  assign rx_data_ready = rx_in.ready;

  assign app_rx_valid = rx_app.valid;
  assign app_rx_data  = rx_app.data;
  assign app_rx_last  = rx_app.last;
  assign rx_app.ready = app_rx_ready;

  //----------------------------
  // transmit path
  //----------------------------
  assign tx_data_valid = tx_net.valid;
  assign tx_data_data  = tx_net.data;
  assign tx_data_last  = tx_net.last;
  assign tx_net.ready  = tx_data_ready;

  listen_port_opener opener0 (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .listen_port_valid (listen_port_valid),
    .listen_port_ready (listen_port_ready),
    .listen_port_data  (listen_port_data)
  );

  stream_fifo #(
    .AW (`RX_FIFO_AW)
  ) rx_fifo0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_in    (rx_in.sink),
    .m_out   (rx_app.source)
  );

  tx_framer framer0 (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .app_tx_valid  (app_tx_valid),
    .app_tx_ready  (app_tx_ready),
    .app_tx_data   (app_tx_data),
    .app_tx_meta   (app_tx_meta),
    .app_tx_last   (app_tx_last),
    .beats_out     (tx_beats.source),
    .tx_meta_valid (tx_meta_valid),
    .tx_meta_ready (tx_meta_ready),
    .tx_meta_data  (tx_meta_data)
  );

  // deep buffer for response data
  stream_fifo #(
    .AW (`TX_FIFO_AW)
  ) tx_fifo0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_in    (tx_beats.sink),
    .m_out   (tx_net.source)
  );

endmodule

`default_nettype wire

/* kvs_net_chk.sv */
//----------------------------
// protocol assertions on the top-level
// streams, bound into the DUT
//----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "kvs_net_defines.svh"

module kvs_net_chk (
  input logic                  aclk,
  input logic                  aresetn,
  input logic                  listen_port_valid,
  input logic                  app_rx_valid,
  input logic                  tx_data_valid,
  input logic                  tx_data_ready,
  input kvs_net_pkg::word_t    tx_data_data,
  input logic                  tx_data_last,
  input logic                  tx_meta_valid,
  input logic                  tx_meta_ready,
  input logic [`TX_META_W-1:0] tx_meta_data
);

  // a stalled word keeps its contents
  tx_meta_hold: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (tx_meta_valid && !tx_meta_ready) |=> (tx_meta_valid && $stable(tx_meta_data))
  ) else $error("tx_meta changed while stalled");

  tx_data_hold: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (tx_data_valid && !tx_data_ready) |=>
      (tx_data_valid && $stable({tx_data_last, tx_data_data}))
  ) else $error("tx_data changed while stalled");

  // listen requests are single-cycle strobes
  listen_strobe: assert property (
    @(posedge aclk) disable iff (!aresetn)
    listen_port_valid |=> !listen_port_valid
  ) else $error("listen_port_valid high on two consecutive cycles");

  rx_idle_after_reset: assert property (
    @(posedge aclk) $rose(aresetn) |-> !app_rx_valid
  ) else $error("app_rx_valid high right after reset");

endmodule

bind kvs_net_top kvs_net_chk chk0 (
  .aclk              (aclk),
  .aresetn           (aresetn),
  .listen_port_valid (listen_port_valid),
  .app_rx_valid      (app_rx_valid),
  .tx_data_valid     (tx_data_valid),
  .tx_data_ready     (tx_data_ready),
  .tx_data_data      (tx_data_data),
  .tx_data_last      (tx_data_last),
  .tx_meta_valid     (tx_meta_valid),
  .tx_meta_ready     (tx_meta_ready),
  .tx_meta_data      (tx_meta_data)
);

`default_nettype wire

/* tb_kvs_net.sv */
//----------------------------
// directed testbench of the network wrapper:
// clock, reset, LFSR stimulus, monitors, watchdog
//----------------------------
`timescale 1ns/100ps
`default_nettype none

`include "kvs_net_defines.svh"

module tb_kvs_net;

  localparam int CLK_NS = 20;
  localparam logic [31:0] SEED = 32'hf73e_2d51;
  localparam int DRAIN_LIMIT = 3000;

  // cycle budgets of the tests
  localparam int RESET_CYC  = 10;
  localparam int LISTEN_CYC = `LISTEN_DELAY + 100;
  localparam int RX_CYC     = 800;
  localparam int TXMSG_CYC  = 400;
  localparam int METAQ_CYC  = 400;
  localparam int TXFULL_CYC = 6000;
  localparam int TEST_CYC   = RESET_CYC + LISTEN_CYC + 2 * RX_CYC + TXMSG_CYC + METAQ_CYC
                              + TXFULL_CYC;
  localparam int WATCHDOG_NS = 2 * (TEST_CYC + `LISTEN_DELAY) * CLK_NS;

  logic                  aclk;
  logic                  aresetn;
  logic                  listen_port_valid;
  logic                  listen_port_ready;
  kvs_net_pkg::port_t    listen_port_data;
  logic                  rx_data_valid;
  logic                  rx_data_ready;
  kvs_net_pkg::word_t    rx_data_data;
  logic                  rx_data_last;
  logic                  app_rx_valid;
  logic                  app_rx_ready = 1'b1;
  kvs_net_pkg::word_t    app_rx_data;
  logic                  app_rx_last;
  logic                  app_tx_valid;
  logic                  app_tx_ready;
  kvs_net_pkg::word_t    app_tx_data;
  kvs_net_pkg::meta_t    app_tx_meta;
  logic                  app_tx_last;
  logic                  tx_data_valid;
  logic                  tx_data_ready;
  kvs_net_pkg::word_t    tx_data_data;
  logic                  tx_data_last;
  logic                  tx_meta_valid;
  logic                  tx_meta_ready;
  logic [`TX_META_W-1:0] tx_meta_data;

  logic [31:0] lfsr;
  logic [31:0] ready_lfsr;
  logic        rx_ready_random;
  int          value_errors;
  int          other_errors;
  int          cyc;
  int          first_req_cyc;

  // expected output words, {last, data} for the streams
  logic [64:0] rx_exp[$];
  logic [64:0] txd_exp[$];
  logic [31:0] txm_exp[$];
  logic [15:0] ports_seen[$];

  kvs_net_top dut0 (.*);

  always #(CLK_NS / 2) aclk = ~aclk;

  always @(posedge aclk) begin
    if (!aresetn) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  //----------------------------
  // random numbers
  //----------------------------
  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic ready_bit();
    ready_lfsr = lfsr_step(ready_lfsr);
    return ready_lfsr[0];
  endfunction

  always @(negedge aclk) begin
    if (rx_ready_random) begin
      app_rx_ready = ready_bit();
    end else begin
      app_rx_ready = 1'b1;
    end
  end

  //----------------------------
  // checking and output monitors
  //----------------------------
  task automatic check_value(input string name, input logic [64:0] exp,
                             input logic [64:0] act);
    assert (act === exp) else begin
      value_errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // sampled mid low phase, inputs settle at the falling edge
  always begin
    @(negedge aclk);
    #5;
    if (aresetn) begin
      if (listen_port_valid && listen_port_ready) begin
        if (ports_seen.size() == 0) begin
          first_req_cyc = cyc;
        end
        ports_seen.push_back(listen_port_data);
      end
      if (app_rx_valid && app_rx_ready) begin
        assert (rx_exp.size() > 0) else begin
          other_errors++;
          $display("app_rx produced a beat that was never sent, at %0t", $time);
        end
        if (rx_exp.size() > 0) begin
          check_value("app_rx {last,data}", rx_exp.pop_front(), {app_rx_last, app_rx_data});
        end
      end
      if (tx_data_valid && tx_data_ready) begin
        assert (txd_exp.size() > 0) else begin
          other_errors++;
          $display("tx_data produced a beat that was never sent, at %0t", $time);
        end
        if (txd_exp.size() > 0) begin
          check_value("tx_data {last,data}", txd_exp.pop_front(),
                      {tx_data_last, tx_data_data});
        end
      end
      if (tx_meta_valid && tx_meta_ready) begin
        assert (txm_exp.size() > 0) else begin
          other_errors++;
          $display("tx_meta produced a word with no message behind it, at %0t", $time);
        end
        if (txm_exp.size() > 0) begin
          check_value("tx_meta_data", 65'(txm_exp.pop_front()), 65'(tx_meta_data));
        end
      end
    end
  end

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (rx_exp.size() + txd_exp.size() + txm_exp.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge aclk);
      waited++;
    end
    // late extra beats show up in the monitor
    repeat (5) @(negedge aclk);
    assert (rx_exp.size() + txd_exp.size() + txm_exp.size() == 0) else begin
      other_errors++;
      $display("%s: words still missing after %0d cycles", what, waited);
    end
    rx_exp.delete();
    txd_exp.delete();
    txm_exp.delete();
  endtask

  task automatic watch_stall(input int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < limit; i++) begin
      @(negedge aclk);
      #5;
      if (app_tx_valid && !app_tx_ready) begin
        seen = 1'b1;
        break;
      end
    end
  endtask

  //----------------------------
  // stimulus
  //----------------------------
  task automatic send_rx_beat(input logic [63:0] word, input logic last);
    @(negedge aclk);
    rx_data_valid = 1'b1;
    rx_data_data  = word;
    rx_data_last  = last;
    #5;
    while (!rx_data_ready) begin
      @(negedge aclk);
      #5;
    end
    rx_exp.push_back({last, word});
  endtask

  task automatic send_tx_beat(input logic [63:0] word, input logic [63:0] meta,
                              input logic last);
    @(negedge aclk);
    app_tx_valid = 1'b1;
    app_tx_data  = word;
    app_tx_meta  = meta;
    app_tx_last  = last;
    #5;
    while (!app_tx_ready) begin
      @(negedge aclk);
      #5;
    end
    txd_exp.push_back({last, word});
  endtask

  // session from the first beat, 8 bytes per beat in the high half
  task automatic send_message(input int beats);
    logic [63:0] meta;
    logic [15:0] session;
    for (int b = 0; b < beats; b++) begin
      meta = rand_bits(64);
      if (b == 0) begin
        session = meta[15:0];
      end
      send_tx_beat(rand_bits(64), meta, b == beats - 1);
    end
    txm_exp.push_back({16'(8 * beats), session});
  endtask

  task automatic tx_idle();
    @(negedge aclk);
    app_tx_valid = 1'b0;
    app_tx_last  = 1'b0;
  endtask

  //----------------------------
  // tests
  //----------------------------
  task automatic check_idle_outputs();
    check_value("listen_port_valid", 65'(0), 65'(listen_port_valid));
    check_value("app_rx_valid", 65'(0), 65'(app_rx_valid));
    check_value("tx_data_valid", 65'(0), 65'(tx_data_valid));
    check_value("tx_meta_valid", 65'(0), 65'(tx_meta_valid));
    // empty FIFO accepts at once
    check_value("rx_data_ready", 65'(1), 65'(rx_data_ready));
  endtask

  task automatic test_reset();
    aresetn = 1'b0;
    repeat (3) begin
      @(negedge aclk);
      check_idle_outputs();
    end
    aresetn = 1'b1;
    @(negedge aclk);
    check_idle_outputs();
  endtask

  task automatic test_listen();
    int waited;
    waited = 0;
    while (ports_seen.size() < 8 && waited < LISTEN_CYC) begin
      @(negedge aclk);
      waited++;
    end
    repeat (50) @(negedge aclk);
    assert (ports_seen.size() == 8) else begin
      other_errors++;
      $display("expected 8 listen requests, saw %0d", ports_seen.size());
    end
    assert (first_req_cyc >= `LISTEN_DELAY) else begin
      other_errors++;
      $display("first listen request came after only %0d cycles", first_req_cyc);
    end
    for (int i = 0; i < ports_seen.size() && i < 8; i++) begin
      check_value("listen_port_data", 65'(16'd2880 + 16'(i)), 65'(ports_seen[i]));
    end
  endtask

  task automatic test_rx(input logic random_ready);
    int len;
    rx_ready_random = random_ready;
    for (int p = 0; p < 20; p++) begin
      len = 1 + int'(rand_bits(3));
      for (int b = 0; b < len; b++) begin
        send_rx_beat(rand_bits(64), b == len - 1);
      end
    end
    @(negedge aclk);
    rx_data_valid = 1'b0;
    wait_drain("rx packets");
    rx_ready_random = 1'b0;
  endtask

  task automatic test_tx_messages();
    for (int m = 0; m < 10; m++) begin
      send_message(int'(rand_bits(3)) % 6 + 1);
    end
    tx_idle();
    wait_drain("tx messages");
  endtask

  task automatic test_meta_backpressure();
    logic stalled;
    @(negedge aclk);
    tx_meta_ready = 1'b0;
    fork
      begin
        for (int m = 0; m < 20; m++) begin
          send_message(1);
        end
        tx_idle();
      end
      begin
        watch_stall(METAQ_CYC, stalled);
        assert (stalled) else begin
          other_errors++;
          $display("app_tx_ready never dropped with the metadata queue blocked");
        end
        repeat (10) @(negedge aclk);
        tx_meta_ready = 1'b1;
      end
    join
    wait_drain("tx metadata back-pressure");
  endtask

  task automatic test_tx_fill();
    logic stalled;
    @(negedge aclk);
    tx_data_ready = 1'b0;
    fork
      begin
        for (int m = 0; m < 34; m++) begin
          send_message(64);
        end
        tx_idle();
      end
      begin
        watch_stall(2 ** `TX_FIFO_AW + 200, stalled);
        assert (stalled) else begin
          other_errors++;
          $display("app_tx_ready never dropped with the transmit FIFO blocked");
        end
        repeat (10) @(negedge aclk);
        tx_data_ready = 1'b1;
      end
    join
    wait_drain("tx FIFO back-pressure");
  endtask

  //----------------------------
  // run
  //----------------------------
  initial begin
    aclk              = 1'b0;
    aresetn           = 1'b0;
    listen_port_ready = 1'b1;
    rx_data_valid     = 1'b0;
    rx_data_data      = '0;
    rx_data_last      = 1'b0;
    app_tx_valid      = 1'b0;
    app_tx_data       = '0;
    app_tx_meta       = '0;
    app_tx_last       = 1'b0;
    tx_data_ready     = 1'b1;
    tx_meta_ready     = 1'b1;
    lfsr              = SEED;
    ready_lfsr        = SEED;
    rx_ready_random   = 1'b0;
    value_errors      = 0;
    other_errors      = 0;
    first_req_cyc     = -1;

    test_reset();
    test_listen();
    test_rx(1'b0);
    test_rx(1'b1);
    test_tx_messages();
    test_meta_backpressure();
    test_tx_fill();

    $display("value mismatches: %0d, other failures: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
kvs_net_pkg.sv
stream_if.sv
stream_fifo.sv
listen_port_opener.sv
tx_framer.sv
kvs_net_top.sv
kvs_net_chk.sv
tb_kvs_net.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_kvs_net \
  -Mdir obj_dir -o sim_kvs_net > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_kvs_net > sim.log 2>&1

grep -qx "TEST OK" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }
